//--- hdl/mem_pipe_pkg.sv
// word type, rv32 instruction views, pipeline records, stall states and opcode constants
package mem_pipe_pkg;

    typedef logic [31:0] word_t;

    // I-type fields, lw takes its offset from here
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // S-type fields, sw splits its offset around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        i_fmt_t itype;
        s_fmt_t stype;
    } rv32_instr_u;

    // handed from fetch to the data side on every move
    typedef struct packed {
        word_t       pc;
        rv32_instr_u instr;
    } fetch_rec_t;

    typedef enum logic [1:0] {
        KIND_NONE  = 2'd0,
        KIND_LOAD  = 2'd1,
        KIND_STORE = 2'd2
    } rec_kind_t;

    // data is the loaded word for lw, the written word for sw
    typedef struct packed {
        word_t       pc;
        rv32_instr_u instr;
        rec_kind_t   kind;
        word_t       addr;
        word_t       data;
    } retire_rec_t;

    typedef enum logic [1:0] {
        moving    = 2'd0,
        wait_imem = 2'd1,
        wait_dmem = 2'd2,
        imem_dmem = 2'd3
    } stall_state_t;

    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [2:0] F3_WORD   = 3'b010;

    // addi x0, x0, 0
    localparam word_t NOP_WORD = 32'h0000_0013;

endpackage

//--- hdl/stall_ctrl.sv
// four-state stall controller that turns memory port activity into the move pulse
`timescale 1ns/1ps

module stall_ctrl
    import mem_pipe_pkg::*;
(
    input  logic clk,
    input  logic rst,

    input  logic imem_req,
    input  logic dmem_req,
    input  logic imem_resp,
    input  logic dmem_resp,
    input  logic retire_stall,

    output logic move
);

    stall_state_t curr_state;
    stall_state_t next_state;

    // a request stays open past this cycle unless its response is here
    logic imem_open;
    logic dmem_open;

    assign imem_open = imem_req && !imem_resp;
    assign dmem_open = dmem_req && !dmem_resp;

    // state that matches whatever is still outstanding
    function automatic stall_state_t pick_state(input logic i_open, input logic d_open);
        stall_state_t st;
        if (i_open && d_open) begin
            st = imem_dmem;
        end else if (i_open) begin
            st = wait_imem;
        end else if (d_open) begin
            st = wait_dmem;
        end else begin
            st = moving;
        end
        return st;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            curr_state <= wait_imem;
        end else begin
            curr_state <= next_state;
        end
    end

    always_comb begin
        next_state = curr_state;
        unique case (curr_state)
            moving: begin
                // a move always launches the next fetch
                if (move) begin
                    next_state = wait_imem;
                end
            end
            wait_imem: begin
                if (imem_resp) begin
                    next_state = pick_state(1'b0, dmem_open);
                end else if (dmem_open) begin
                    next_state = imem_dmem;
                end
            end
            wait_dmem: begin
                if (dmem_resp) begin
                    next_state = pick_state(imem_open, 1'b0);
                end else if (imem_open) begin
                    next_state = imem_dmem;
                end
            end
            imem_dmem: begin
                if (imem_resp || dmem_resp) begin
                    next_state = pick_state(imem_open, dmem_open);
                end
            end
            default: next_state = wait_imem;
        endcase
    end

    // held low while the retire register is full and not taken
    assign move = (curr_state == moving) && !retire_stall;

endmodule

//--- hdl/fetch_unit.sv
// program counter, instruction memory request and fetched-instruction holding register
`timescale 1ns/1ps

module fetch_unit
    import mem_pipe_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic       clk,
    input  logic       rst,

    input  logic       move,

    output word_t      imem_addr,
    output logic       imem_req,
    input  logic       imem_resp,
    input  word_t      imem_rdata,

    output fetch_rec_t fetched
);

    // pc of the word being fetched or just returned
    word_t       pc;
    rv32_instr_u hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= RESET_PC;
            imem_req <= 1'b1;
            hold     <= NOP_WORD;
        end else if (move) begin
            // next fetch starts right after the move edge
            pc       <= pc + 32'd4;
            imem_req <= 1'b1;
        end else if (imem_req && imem_resp) begin
            hold     <= imem_rdata;
            imem_req <= 1'b0;
        end
    end

    assign imem_addr = pc;

    // the data side latches this on the move edge
    assign fetched.pc    = pc;
    assign fetched.instr = hold;

endmodule

//--- hdl/data_unit.sv
// lw/sw decode, register file, data memory access and retire register with its handshake
`timescale 1ns/1ps

module data_unit
    import mem_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        move,
    input  fetch_rec_t  fetched,

    output word_t       dmem_addr,
    output word_t       dmem_wdata,
    output logic        dmem_we,
    output logic        dmem_req,
    input  logic        dmem_resp,
    input  word_t       dmem_rdata,

    output logic        retire_stall,
    output logic        retire_valid,
    output retire_rec_t retire,
    input  logic        retire_ready
);

    word_t       regs [32];

    // record of the instruction currently owned by the data side
    retire_rec_t cur_rec;
    logic        cur_valid;

    rv32_instr_u in_instr;
    logic        in_load;
    logic        in_store;
    word_t       in_offset;
    word_t       in_addr;
    retire_rec_t in_rec;

    logic        load_done;

    assign in_instr = fetched.instr;
    assign in_load  = (in_instr.itype.opcode == OPC_LOAD) && (in_instr.itype.funct3 == F3_WORD);
    assign in_store = (in_instr.stype.opcode == OPC_STORE) && (in_instr.stype.funct3 == F3_WORD);

    // offset comes through the view that matches the opcode
    always_comb begin
        if (in_store) begin
            in_offset = {{20{in_instr.stype.imm_hi[6]}}, in_instr.stype.imm_hi,
                         in_instr.stype.imm_lo};
        end else begin
            in_offset = {{20{in_instr.itype.imm[11]}}, in_instr.itype.imm};
        end
    end

    assign in_addr = regs[in_instr.itype.rs1] + in_offset;

    always_comb begin
        in_rec.pc    = fetched.pc;
        in_rec.instr = fetched.instr;
        in_rec.kind  = KIND_NONE;
        in_rec.addr  = '0;
        in_rec.data  = '0;
        if (in_load) begin
            in_rec.kind = KIND_LOAD;
            in_rec.addr = in_addr;
        end else if (in_store) begin
            in_rec.kind = KIND_STORE;
            in_rec.addr = in_addr;
            in_rec.data = regs[in_instr.stype.rs2];
        end
    end

    assign load_done = dmem_req && dmem_resp && (cur_rec.kind == KIND_LOAD);

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_valid <= 1'b0;
            dmem_req  <= 1'b0;
        end else if (move) begin
            cur_valid <= 1'b1;
            dmem_req  <= in_load || in_store;
        end else if (dmem_resp) begin
            dmem_req  <= 1'b0;
        end
    end

    // load data lands in the record at the response edge
    always_ff @(posedge clk) begin
        if (move) begin
            cur_rec <= in_rec;
        end else if (load_done) begin
            cur_rec.data <= dmem_rdata;
        end
    end

    // x0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (load_done && (cur_rec.instr.itype.rd != 5'd0)) begin
            regs[cur_rec.instr.itype.rd] <= dmem_rdata;
        end
    end

    // request fields stay put until the next move
    assign dmem_addr  = cur_rec.addr;
    assign dmem_wdata = cur_rec.data;
    assign dmem_we    = dmem_req && (cur_rec.kind == KIND_STORE);

    // first move after reset has nothing to retire yet
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else if (move && cur_valid) begin
            retire_valid <= 1'b1;
        end else if (retire_valid && retire_ready) begin
            retire_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (move && cur_valid) begin
            retire <= cur_rec;
        end
    end

    assign retire_stall = retire_valid && !retire_ready;

endmodule

//--- hdl/mem_pipe_top.sv
// top level joining stall control, fetch and data units to the memory ports and retire stream
`timescale 1ns/1ps

module mem_pipe_top
    import mem_pipe_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,

    // instruction memory
    output word_t       imem_addr,
    output logic        imem_req,
    input  logic        imem_resp,
    input  word_t       imem_rdata,

    // data memory
    output word_t       dmem_addr,
    output word_t       dmem_wdata,
    output logic        dmem_we,
    output logic        dmem_req,
    input  logic        dmem_resp,
    input  word_t       dmem_rdata,

    // retire stream
    output logic        retire_valid,
    output retire_rec_t retire,
    input  logic        retire_ready
);

    logic       move;
    logic       retire_stall;
    fetch_rec_t fetched;

    stall_ctrl u_stall_ctrl (
        .clk          (clk),
        .rst          (rst),
        .imem_req     (imem_req),
        .dmem_req     (dmem_req),
        .imem_resp    (imem_resp),
        .dmem_resp    (dmem_resp),
        .retire_stall (retire_stall),
        .move         (move)
    );

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch_unit (
        .clk        (clk),
        .rst        (rst),
        .move       (move),
        .imem_addr  (imem_addr),
        .imem_req   (imem_req),
        .imem_resp  (imem_resp),
        .imem_rdata (imem_rdata),
        .fetched    (fetched)
    );

    data_unit u_data_unit (
        .clk          (clk),
        .rst          (rst),
        .move         (move),
        .fetched      (fetched),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_we      (dmem_we),
        .dmem_req     (dmem_req),
        .dmem_resp    (dmem_resp),
        .dmem_rdata   (dmem_rdata),
        .retire_stall (retire_stall),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready)
    );

endmodule

//--- tb/mem_pipe_checker.sv
// bound assertions on memory port stability, retire stability and state after reset
`timescale 1ns/1ps

module mem_pipe_checker
    import mem_pipe_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input word_t       imem_addr,
    input logic        imem_req,
    input logic        imem_resp,
    input word_t       dmem_addr,
    input word_t       dmem_wdata,
    input logic        dmem_we,
    input logic        dmem_req,
    input logic        dmem_resp,
    input logic        retire_valid,
    input retire_rec_t retire,
    input logic        retire_ready
);

    // an open request keeps its address until resp
    imem_hold: assert property (@(posedge clk) disable iff (rst)
        imem_req && !imem_resp |=> imem_req && $stable(imem_addr))
        else $error("imem request dropped or changed before resp");

    dmem_hold: assert property (@(posedge clk) disable iff (rst)
        dmem_req && !dmem_resp |=> dmem_req && $stable(dmem_addr)
                                   && $stable(dmem_wdata) && $stable(dmem_we))
        else $error("dmem request dropped or changed before resp");

    retire_hold: assert property (@(posedge clk) disable iff (rst)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire))
        else $error("retire record changed while not taken");

    after_reset: assert property (@(posedge clk)
        $fell(rst) |=> !dmem_req && !retire_valid)
        else $error("dmem_req or retire_valid high right after reset");

endmodule

bind mem_pipe_top mem_pipe_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .imem_addr    (imem_addr),
    .imem_req     (imem_req),
    .imem_resp    (imem_resp),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_we      (dmem_we),
    .dmem_req     (dmem_req),
    .dmem_resp    (dmem_resp),
    .retire_valid (retire_valid),
    .retire       (retire),
    .retire_ready (retire_ready)
);

//--- tb/mem_pipe_tb.sv
// testbench with memory models of random latency, a retire reference model and checks
`timescale 1ns/1ps

module mem_pipe_tb
    import mem_pipe_pkg::*;
();

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam word_t NOP      = 32'h0000_0013;
    localparam int    TIMEOUT  = 200;

    logic        clk;
    logic        rst;
    word_t       imem_addr;
    logic        imem_req;
    logic        imem_resp;
    word_t       imem_rdata;
    word_t       dmem_addr;
    word_t       dmem_wdata;
    logic        dmem_we;
    logic        dmem_req;
    logic        dmem_resp;
    word_t       dmem_rdata;
    logic        retire_valid;
    retire_rec_t retire;
    logic        retire_ready;

    // vector image: program at 0, data at 64, stores at 128, counts at 192
    word_t vec [256];
    word_t mem_model [64];
    word_t ref_mem [64];
    word_t ref_regs [32];
    word_t ref_pc;
    int    n_instr;
    int    n_stores;
    int    store_seen;
    int    dmem_ops;
    int    ref_ops;
    int    retired;
    logic  i_busy;
    logic  d_busy;
    int    i_wait;
    int    d_wait;
    logic  passed;
    logic  fail_shown;

    mem_pipe_top #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .imem_addr    (imem_addr),
        .imem_req     (imem_req),
        .imem_resp    (imem_resp),
        .imem_rdata   (imem_rdata),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_we      (dmem_we),
        .dmem_req     (dmem_req),
        .dmem_resp    (dmem_resp),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        fail_shown = 1'b1;
        $display("test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic compare_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    // words past the program read as nop
    function automatic word_t fetch_word(input word_t addr);
        word_t idx;
        idx = (addr - RESET_PC) >> 2;
        if (idx < word_t'(n_instr)) begin
            return vec[idx[5:0]];
        end
        return NOP;
    endfunction

    task automatic serve_imem();
        if (imem_resp) begin
            imem_resp = 1'b0;
        end else if (imem_req) begin
            if (!i_busy) begin
                i_busy = 1'b1;
                i_wait = int'($urandom_range(3, 0));
            end
            if (i_wait != 0) begin
                i_wait--;
            end else begin
                imem_rdata = fetch_word(imem_addr);
                imem_resp  = 1'b1;
                i_busy     = 1'b0;
            end
        end
    endtask

    task automatic serve_dmem();
        if (dmem_resp) begin
            dmem_resp = 1'b0;
        end else if (dmem_req) begin
            if (!d_busy) begin
                d_busy = 1'b1;
                d_wait = int'($urandom_range(3, 0));
            end
            if (d_wait != 0) begin
                d_wait--;
            end else if (dmem_addr >= 32'd256 || dmem_addr[1:0] != 2'd0) begin
                fail_run("data memory access outside the 64 words or not word aligned");
            end else if (dmem_we && store_seen >= n_stores) begin
                fail_run("the DUT wrote more stores than the vectors expect");
            end else begin
                if (dmem_we) begin
                    compare_value("dmem_addr", dmem_addr, vec[128 + 2 * store_seen]);
                    compare_value("dmem_wdata", dmem_wdata, vec[129 + 2 * store_seen]);
                    mem_model[dmem_addr[7:2]] = dmem_wdata;
                    store_seen++;
                end else begin
                    dmem_rdata = mem_model[dmem_addr[7:2]];
                end
                dmem_resp = 1'b1;
                d_busy    = 1'b0;
                dmem_ops++;
            end
        end
    endtask

    // walk the program in order and predict the next record
    task automatic check_retire();
        word_t ins;
        word_t kind;
        word_t addr;
        word_t data;
        ins  = fetch_word(ref_pc);
        kind = 32'd0;
        addr = 32'd0;
        data = 32'd0;
        if (ins[6:0] == 7'h03 && ins[14:12] == 3'd2) begin
            kind = 32'd1;
            addr = ref_regs[ins[19:15]] + {{20{ins[31]}}, ins[31:20]};
            data = ref_mem[addr[7:2]];
            if (ins[11:7] != 5'd0) begin
                ref_regs[ins[11:7]] = data;
            end
            ref_ops++;
        end else if (ins[6:0] == 7'h23 && ins[14:12] == 3'd2) begin
            kind = 32'd2;
            addr = ref_regs[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            data = ref_regs[ins[24:20]];
            ref_mem[addr[7:2]] = data;
            ref_ops++;
        end
        compare_value("retire.pc", retire.pc, ref_pc);
        compare_value("retire.instr", word_t'(retire.instr), ins);
        compare_value("retire.kind", word_t'(retire.kind), kind);
        compare_value("retire.addr", retire.addr, addr);
        compare_value("retire.data", retire.data, data);
        ref_pc = ref_pc + 32'd4;
        retired++;
    endtask

    initial begin
        int   idle;
        logic seen_iresp;
        clk          = 1'b0;
        rst          = 1'b1;
        imem_resp    = 1'b0;
        imem_rdata   = '0;
        dmem_resp    = 1'b0;
        dmem_rdata   = '0;
        retire_ready = 1'b0;
        i_busy       = 1'b0;
        d_busy       = 1'b0;
        i_wait       = 0;
        d_wait       = 0;
        store_seen   = 0;
        dmem_ops     = 0;
        ref_ops      = 0;
        retired      = 0;
        passed       = 1'b0;
        fail_shown   = 1'b0;
        void'($urandom(7817));
        $readmemh("tb/mem_pipe_vectors.txt", vec);
        n_instr  = int'(vec[192]);
        n_stores = int'(vec[193]);
        for (int i = 0; i < 64; i++) begin
            mem_model[i] = vec[64 + i];
            ref_mem[i]   = vec[64 + i];
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        ref_pc = RESET_PC;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        seen_iresp = 1'b0;
        idle       = 0;
        compare_value("imem_req", word_t'(imem_req), 32'd1);
        while (retired < n_instr) begin
            // quiet data side until the first instruction arrives
            if (!seen_iresp) begin
                compare_value("retire_valid", word_t'(retire_valid), 32'd0);
                compare_value("dmem_req", word_t'(dmem_req), 32'd0);
                compare_value("imem_addr", imem_addr, RESET_PC);
            end
            serve_imem();
            serve_dmem();
            retire_ready = ($urandom_range(3, 0) != 0);
            if (retire_valid && retire_ready) begin
                check_retire();
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    fail_run("no retire record was taken within the timeout");
                end
            end
            if (imem_resp) begin
                seen_iresp = 1'b1;
            end
            @(negedge clk);
        end

        compare_value("store count", word_t'(store_seen), word_t'(n_stores));
        compare_value("data access count", word_t'(dmem_ops), word_t'(ref_ops));
        passed = 1'b1;
        $display("test passed");
        $finish;
    end

    // a stop from a failed assertion ends up here
    final begin
        if (!passed && !fail_shown) begin
            $display("test failed");
        end
    end

endmodule

//--- tb/mem_pipe_vectors.txt
// one hex word per entry: @00 program words, @40 initial data memory (64 words),
// @80 expected stores as address then data, @c0 instruction count then store count
@00
00002083 00402103 00500193 0020a023
01002203 fe40ae23 00802003 0200a023
03002283 0e102e23 00000013
@40
00000010 cafe0001 5a5a0002 5a5a0003 5a5a0004 5a5a0005 5a5a0006 5a5a0007
5a5a0008 5a5a0009 5a5a000a 5a5a000b 5a5a000c 5a5a000d 5a5a000e 5a5a000f
5a5a0010 5a5a0011 5a5a0012 5a5a0013 5a5a0014 5a5a0015 5a5a0016 5a5a0017
5a5a0018 5a5a0019 5a5a001a 5a5a001b 5a5a001c 5a5a001d 5a5a001e 5a5a001f
5a5a0020 5a5a0021 5a5a0022 5a5a0023 5a5a0024 5a5a0025 5a5a0026 5a5a0027
5a5a0028 5a5a0029 5a5a002a 5a5a002b 5a5a002c 5a5a002d 5a5a002e 5a5a002f
5a5a0030 5a5a0031 5a5a0032 5a5a0033 5a5a0034 5a5a0035 5a5a0036 5a5a0037
5a5a0038 5a5a0039 5a5a003a 5a5a003b 5a5a003c 5a5a003d 5a5a003e 5a5a003f
@80
00000010 cafe0001
0000000c cafe0001
00000030 00000000
000000fc 00000010
@c0
0000000b 00000004

//--- mem_pipe_top.f
hdl/mem_pipe_pkg.sv
hdl/stall_ctrl.sv
hdl/fetch_unit.sv
hdl/data_unit.sv
hdl/mem_pipe_top.sv
tb/mem_pipe_checker.sv
tb/mem_pipe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mem_pipe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mem_pipe_top.f \
    --top-module mem_pipe_tb -o sim_mem_pipe

# the simulator exits nonzero on failure, the log search decides the result
./obj_dir/sim_mem_pipe > sim.log 2>&1 || true
cat sim.log

if grep -q "^test passed$" sim.log; then
    exit 0
else
    exit 1
fi
